//--- include/slm_bridge_defines.svh
////////////////////////////////////////
// bridge-wide tuning constants
//   uart bit period, spi clock divider,
//   readback depth, modulator reset hold
////////////////////////////////////////
`ifndef SLM_BRIDGE_DEFINES_SVH
`define SLM_BRIDGE_DEFINES_SVH

// sys_clk cycles per uart bit
// 100 MHz / 115200 baud
`define SLM_CLKS_PER_BIT 868

// sys_clk cycles per half sck period
// full sck period is twice this
`define SLM_SPI_HALF_PERIOD 4

// readback fifo entries
`define SLM_QUEUE_DEPTH 4

// modulator reset hold after system reset
// cycles of sys_clk
`define SLM_RESET_STRETCH 10

`endif

//--- logic/slm_bridge_pkg.sv
////////////////////////////////////////
// shared bridge types
//   byte_t      payload byte
//   spi_frame_t addr/data spi word
//   spi_pins_t  modulator spi outputs
////////////////////////////////////////
`default_nettype none

package slm_bridge_pkg;

  // single payload byte, uart and spi side
  typedef logic [7:0] byte_t;

  // one 16-bit spi word
  // addr goes out first on the wire
  typedef struct packed {
    byte_t addr;
    byte_t data;
  } spi_frame_t;

  // modulator spi pins driven by the master
  typedef struct packed {
    // select, active low
    logic sen;
    // serial clock, idles low
    logic sck;
    // mosi
    logic sdat;
  } spi_pins_t;

endpackage

`default_nettype wire

//--- logic/uart_rx.sv
////////////////////////////////////////
// uart receiver, 8N1
//   two-flop input synchronizer
//   mid-bit sampling fsm
//   one-cycle valid strobe per byte
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "slm_bridge_defines.svh"

module uart_rx
  import slm_bridge_pkg::*;
#(
  parameter int CLKS_PER_BIT = `SLM_CLKS_PER_BIT
) (
  input  logic  sys_clk,
  input  logic  reset_all_cmd_w,
  input  logic  rx_serial_i,
  output logic  rx_valid_o,
  output byte_t rx_byte_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t        state_q;
  logic [1:0]       sync_q;
  logic             rx_sync;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  byte_t            shift_q;

  // line is async to sys_clk
  assign rx_sync = sync_q[1];

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      // idle line is high
      sync_q     <= 2'b11;
      state_q    <= RX_IDLE;
      cnt_q      <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], rx_serial_i};
      rx_valid_o <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q     <= '0;
          bit_idx_q <= '0;
          // falling edge = start bit
          if (!rx_sync) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // check start bit at its middle
          if (cnt_q == HALF_BIT) begin
            cnt_q   <= '0;
            // glitch, not a real start
            state_q <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt_q == FULL_BIT) begin
            cnt_q     <= '0;
            // lsb arrives first
            shift_q   <= {rx_sync, shift_q[7:1]};
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          // middle of stop bit
          if (cnt_q == FULL_BIT) begin
            cnt_q   <= '0;
            state_q <= RX_IDLE;
            // framing error, drop byte
            if (rx_sync) begin
              rx_valid_o <= 1'b1;
              rx_byte_o  <= shift_q;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
////////////////////////////////////////
// uart transmitter, 8N1
//   start, 8 data lsb first, stop
//   busy from start pulse to stop end
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "slm_bridge_defines.svh"

module uart_tx
  import slm_bridge_pkg::*;
#(
  parameter int CLKS_PER_BIT = `SLM_CLKS_PER_BIT
) (
  input  logic  sys_clk,
  input  logic  reset_all_cmd_w,
  input  logic  tx_start_i,
  input  byte_t tx_byte_i,
  output logic  tx_busy_o,
  output logic  tx_serial_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  tx_state_t        state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  byte_t            shift_q;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q     <= TX_IDLE;
      cnt_q       <= '0;
      bit_idx_q   <= '0;
      tx_busy_o   <= 1'b0;
      tx_serial_o <= 1'b1;
    end else begin
      case (state_q)
        TX_IDLE: begin
          cnt_q     <= '0;
          bit_idx_q <= '0;
          if (tx_start_i) begin
            // latch byte, drive start bit next cycle
            shift_q     <= tx_byte_i;
            tx_serial_o <= 1'b0;
            tx_busy_o   <= 1'b1;
            state_q     <= TX_START;
          end
        end
        TX_START: begin
          if (cnt_q == FULL_BIT) begin
            cnt_q       <= '0;
            tx_serial_o <= shift_q[0];
            state_q     <= TX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        TX_DATA: begin
          if (cnt_q == FULL_BIT) begin
            cnt_q <= '0;
            if (bit_idx_q == 3'd7) begin
              // stop bit
              tx_serial_o <= 1'b1;
              state_q     <= TX_STOP;
            end else begin
              tx_serial_o <= shift_q[1];
              shift_q     <= {1'b0, shift_q[7:1]};
              bit_idx_q   <= bit_idx_q + 1'b1;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          if (cnt_q == FULL_BIT) begin
            cnt_q     <= '0;
            tx_busy_o <= 1'b0;
            state_q   <= TX_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // the drain side must wait for busy to clear
  a_no_start_when_busy : assert property (
    @(posedge sys_clk) disable iff (reset_all_cmd_w)
    tx_start_i |-> !tx_busy_o
  );

endmodule

`default_nettype wire

//--- logic/spi_cmd_pairer.sv
////////////////////////////////////////
// uart byte pairing
//   odd byte held as address
//   even byte completes the frame
//   requester side of req/ack
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_pairer
  import slm_bridge_pkg::*;
(
  input  logic       sys_clk,
  input  logic       reset_all_cmd_w,
  input  logic       rx_valid_i,
  input  byte_t      rx_byte_i,
  input  logic       xfer_ack_i,
  output spi_frame_t frame_o,
  output logic       xfer_req_o
);

  // byte shifted in most recently
  byte_t held_q;
  // high once the address byte is in
  logic  odd_q;
  logic  launch;

  // one frame in flight at a time
  // new request only once ack is back low
  assign launch = rx_valid_i && odd_q && !xfer_req_o && !xfer_ack_i;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      odd_q      <= 1'b0;
      xfer_req_o <= 1'b0;
    end else begin
      if (rx_valid_i) begin
        odd_q <= ~odd_q;
      end
      if (launch) begin
        xfer_req_o <= 1'b1;
      end else if (xfer_req_o && xfer_ack_i) begin
        // transfer done, release request
        xfer_req_o <= 1'b0;
      end
    end
  end

  // payload, no reset
  always_ff @(posedge sys_clk) begin
    if (rx_valid_i) begin
      held_q <= rx_byte_i;
    end
    // held byte moves into the addr half
    if (launch) begin
      frame_o.addr <= held_q;
      frame_o.data <= rx_byte_i;
    end
  end

  // master shifts from frame_o for the whole transfer
  a_frame_stable : assert property (
    @(posedge sys_clk) disable iff (reset_all_cmd_w)
    xfer_req_o |=> $stable(frame_o)
  );

endmodule

`default_nettype wire

//--- logic/spi_master.sv
////////////////////////////////////////
// spi master, mode 0, 16-bit frames
//   msb first, mosi on falling sck
//   miso sampled on rising sck
//   reply = last 8 miso bits
//   acknowledging side of req/ack
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "slm_bridge_defines.svh"

module spi_master
  import slm_bridge_pkg::*;
(
  input  logic       sys_clk,
  input  logic       reset_all_cmd_w,
  input  logic       xfer_req_i,
  input  spi_frame_t frame_i,
  input  logic       sout_i,
  output spi_pins_t  spi_o,
  output logic       xfer_ack_o,
  output logic       reply_valid_o,
  output byte_t      reply_byte_o
);

  localparam int HP   = `SLM_SPI_HALF_PERIOD;
  localparam int CW   = (HP > 1) ? $clog2(HP) : 1;
  localparam logic [CW-1:0] HALF_END = CW'(HP - 1);

  typedef enum logic [1:0] {SPI_IDLE, SPI_RUN, SPI_DONE, SPI_ACK} spi_state_t;

  spi_state_t  state_q;
  logic [CW-1:0] cnt_q;
  logic [3:0]  bit_cnt_q;
  spi_frame_t  tx_q;
  byte_t       rx_q;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q       <= SPI_IDLE;
      cnt_q         <= '0;
      bit_cnt_q     <= '0;
      spi_o.sen     <= 1'b1;
      spi_o.sck     <= 1'b0;
      spi_o.sdat    <= 1'b0;
      xfer_ack_o    <= 1'b0;
      reply_valid_o <= 1'b0;
    end else begin
      reply_valid_o <= 1'b0;
      case (state_q)
        SPI_IDLE: begin
          cnt_q     <= '0;
          bit_cnt_q <= '0;
          if (xfer_req_i) begin
            // select and present the first bit
            spi_o.sen  <= 1'b0;
            spi_o.sdat <= frame_i.addr[7];
            tx_q       <= frame_i;
            state_q    <= SPI_RUN;
          end
        end
        SPI_RUN: begin
          if (cnt_q == HALF_END) begin
            cnt_q     <= '0;
            spi_o.sck <= ~spi_o.sck;
            if (!spi_o.sck) begin
              // rising edge, take miso
              rx_q <= {rx_q[6:0], sout_i};
            end else if (bit_cnt_q == 4'd15) begin
              // last falling edge
              state_q <= SPI_DONE;
            end else begin
              // falling edge, next mosi bit
              bit_cnt_q  <= bit_cnt_q + 1'b1;
              spi_o.sdat <= tx_q[14];
              tx_q       <= spi_frame_t'({tx_q[14:0], 1'b0});
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        SPI_DONE: begin
          // deselect, hand reply to the queue
          spi_o.sen     <= 1'b1;
          xfer_ack_o    <= 1'b1;
          reply_valid_o <= 1'b1;
          state_q       <= SPI_ACK;
        end
        default: begin
          // wait for requester to drop req
          if (!xfer_req_i) begin
            xfer_ack_o <= 1'b0;
            state_q    <= SPI_IDLE;
          end
        end
      endcase
    end
  end

  // reply byte captured alongside the ack
  always_ff @(posedge sys_clk) begin
    if (state_q == SPI_DONE) begin
      reply_byte_o <= rx_q;
    end
  end

  // no stray clocks outside a selected frame
  a_sck_idle_low : assert property (
    @(posedge sys_clk) disable iff (reset_all_cmd_w)
    spi_o.sen |-> !spi_o.sck
  );

endmodule

`default_nettype wire

//--- logic/readback_queue.sv
////////////////////////////////////////
// readback byte fifo
//   circular buffer with count
//   pop-then-start drain to uart tx
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "slm_bridge_defines.svh"

module readback_queue
  import slm_bridge_pkg::*;
(
  input  logic  sys_clk,
  input  logic  reset_all_cmd_w,
  input  logic  reply_valid_i,
  input  byte_t reply_byte_i,
  input  logic  tx_busy_i,
  output logic  tx_start_o,
  output byte_t tx_byte_o
);

  localparam int DEPTH = `SLM_QUEUE_DEPTH;
  localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PW-1:0] LAST = PW'(DEPTH - 1);

  byte_t       mem [DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [PW:0] count_q;
  logic        empty;
  logic        full;
  logic        push;
  logic        pop;

  assign empty = (count_q == '0);
  assign full  = (count_q == (PW+1)'(DEPTH));
  // full queue drops the reply
  assign push  = reply_valid_i && !full;
  // hold off while a start is still pending
  assign pop   = !empty && !tx_busy_i && !tx_start_o;

  ////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      tx_start_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q    <= count_q + (PW+1)'(push) - (PW+1)'(pop);
      // start the transmitter the cycle after the pop
      tx_start_o <= pop;
    end
  end

  // storage and output byte
  always_ff @(posedge sys_clk) begin
    if (push) begin
      mem[wr_ptr_q] <= reply_byte_i;
    end
    if (pop) begin
      tx_byte_o <= mem[rd_ptr_q];
    end
  end

  // a pop from an empty queue would wrap the count past depth
  a_no_pop_empty : assert property (
    @(posedge sys_clk) disable iff (reset_all_cmd_w)
    count_q <= (PW+1)'(DEPTH)
  );

endmodule

`default_nettype wire

//--- logic/slm_reset_gen.sv
////////////////////////////////////////
// modulator reset stretcher
//   active-low, held past system reset
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "slm_bridge_defines.svh"

module slm_reset_gen (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  output logic slm_reset_n_o
);

  localparam int STRETCH = `SLM_RESET_STRETCH;
  localparam int CW      = $clog2(STRETCH + 1);

  logic [CW-1:0] cnt_q;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      // reload and hold modulator in reset
      cnt_q         <= CW'(STRETCH);
      slm_reset_n_o <= 1'b0;
    end else if (cnt_q > CW'(1)) begin
      cnt_q <= cnt_q - 1'b1;
    end else begin
      // release on the last count
      cnt_q         <= '0;
      slm_reset_n_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/slm_bridge_top.sv
////////////////////////////////////////
// pc to modulator command bridge
//   uart rx -> pairer -> spi master
//   spi reply -> queue -> uart tx
//   stretched modulator reset
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "slm_bridge_defines.svh"

module slm_bridge_top
  import slm_bridge_pkg::*;
#(
  parameter int CLKS_PER_BIT = `SLM_CLKS_PER_BIT
) (
  input  logic      sys_clk,
  input  logic      reset_all_cmd_w,
  input  logic      uart_rx_i,
  input  logic      sout_i,
  output logic      uart_tx_o,
  output logic      slm_reset_n_o,
  output spi_pins_t spi_o
);

  // pc command path
  logic       rx_valid;
  byte_t      rx_byte;
  spi_frame_t frame;
  logic       xfer_req;
  logic       xfer_ack;
  // readback path
  logic       reply_valid;
  byte_t      reply_byte;
  logic       tx_start;
  byte_t      tx_byte;
  logic       tx_busy;

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
    .sys_clk, .reset_all_cmd_w, .rx_serial_i(uart_rx_i),
    .rx_valid_o(rx_valid), .rx_byte_o(rx_byte)
  );

  spi_cmd_pairer u_pairer (
    .sys_clk, .reset_all_cmd_w, .rx_valid_i(rx_valid), .rx_byte_i(rx_byte),
    .xfer_ack_i(xfer_ack), .frame_o(frame), .xfer_req_o(xfer_req)
  );

  spi_master u_spi_master (
    .sys_clk, .reset_all_cmd_w, .xfer_req_i(xfer_req), .frame_i(frame),
    .sout_i, .spi_o, .xfer_ack_o(xfer_ack), .reply_valid_o(reply_valid),
    .reply_byte_o(reply_byte)
  );

  readback_queue u_queue (
    .sys_clk, .reset_all_cmd_w, .reply_valid_i(reply_valid),
    .reply_byte_i(reply_byte), .tx_busy_i(tx_busy),
    .tx_start_o(tx_start), .tx_byte_o(tx_byte)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .sys_clk, .reset_all_cmd_w, .tx_start_i(tx_start), .tx_byte_i(tx_byte),
    .tx_busy_o(tx_busy), .tx_serial_o(uart_tx_o)
  );

  slm_reset_gen u_reset_gen (
    .sys_clk, .reset_all_cmd_w, .slm_reset_n_o
  );

endmodule

`default_nettype wire

//--- tests/tb_slm_models.sv
////////////////////////////////////////
// testbench models
//   uart byte driver, pc side
//   uart byte monitor, pc side
//   spi slave model of the modulator
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_byte_driver
  import slm_bridge_pkg::*;
#(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic  sys_clk,
  input  logic  send_i,
  input  byte_t byte_i,
  output logic  busy_o,
  output logic  line_o
);

  // start, 8 data lsb first, stop
  task automatic drive_frame(input byte_t b);
    logic [9:0] bits;
    int         i;
    bits = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge sys_clk);
      #1;
      line_o = bits[0];
      bits   = bits >> 1;
      repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
    end
  endtask

  initial begin
    // idle line high
    line_o = 1'b1;
    busy_o = 1'b0;
    forever begin
      @(posedge sys_clk);
      if (send_i) begin
        busy_o = 1'b1;
        drive_frame(byte_i);
        busy_o = 1'b0;
      end
    end
  end

endmodule

module uart_byte_monitor
  import slm_bridge_pkg::*;
#(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic  sys_clk,
  input  logic  line_i,
  output int    count_o,
  output byte_t byte_o,
  output logic  stop_err_o
);

  initial begin
    int    i;
    byte_t shift;
    count_o    = 0;
    byte_o     = '0;
    stop_err_o = 1'b0;
    shift      = '0;
    forever begin
      @(negedge line_i);
      // middle of the start bit
      repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
      if (line_i == 1'b0) begin
        for (i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge sys_clk);
          shift = {line_i, shift[7:1]};
        end
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
        // latest decoded byte and running count
        if (line_i == 1'b1) begin
          byte_o = shift;
          count_o++;
        end else begin
          stop_err_o = 1'b1;
        end
      end
    end
  end

endmodule

module spi_slave_model (
  input  logic        sen_i,
  input  logic        sck_i,
  input  logic        sdat_i,
  output logic        miso_o,
  output logic [15:0] frame_o,
  output int          bits_o,
  output int          count_o
);

  initial begin
    int          rise_cnt;
    logic [15:0] shift;
    logic [7:0]  reply;
    miso_o   = 1'b0;
    frame_o  = '0;
    bits_o   = 0;
    count_o  = 0;
    shift    = '0;
    reply    = '0;
    forever begin
      @(negedge sen_i);
      rise_cnt = 0;
      while (sen_i === 1'b0) begin
        @(posedge sck_i or posedge sen_i);
        if (sen_i === 1'b0) begin
          // mosi stable on rising sck
          shift = {shift[14:0], sdat_i};
          rise_cnt++;
          // answer with the complement of the address
          if (rise_cnt == 8) begin
            reply = ~shift[7:0];
          end
          @(negedge sck_i or posedge sen_i);
          if (sen_i === 1'b0 && rise_cnt >= 8 && rise_cnt < 16) begin
            // settle after the clock edge that moved sck
            #1;
            miso_o = reply[7];
            reply  = {reply[6:0], 1'b0};
          end
        end
      end
      frame_o = shift;
      bits_o  = rise_cnt;
      count_o++;
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_slm_bridge.sv
////////////////////////////////////////
// bridge testbench
//   clock, reset, byte stimulus
//   concurrent checks on frames, readback
//   watchdog and per-test report
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "slm_bridge_defines.svh"

module tb_slm_bridge
  import slm_bridge_pkg::*;
();

  localparam int CPB          = 16;
  localparam int CLK_NS       = 100;
  localparam int STREAM_PAIRS = 6;
  // pairing, odd byte, two readback pairs, then the stream
  localparam int TOTAL_BYTES  = 2 * (4 + STREAM_PAIRS);
  localparam int WATCHDOG_NS  = (TOTAL_BYTES * 20 + 200) * CPB * CLK_NS;
  // spi frame plus one uart frame, with room to spare
  localparam int RB_LIMIT     = 30 * CPB;

  logic        sys_clk;
  logic        reset_all_cmd_w;
  logic        uart_rx;
  logic        uart_tx;
  logic        sout;
  logic        slm_reset_n;
  spi_pins_t   spi;
  // pc side models
  logic        send_req;
  byte_t       pc_byte;
  logic        drv_busy;
  int          rb_count;
  byte_t       rb_byte;
  logic        rb_stop_err;
  // modulator model
  int          frame_count;
  int          frame_bits;
  logic [15:0] last_frame;
  // expected frames in send order
  logic [15:0] exp_frame_mem [64];
  int          exp_n;
  int          since_rst;
  logic        reset_settled;
  logic        expect_idle;
  logic        test_end;
  int          err_count;
  int          test_err_base;
  int          test_num;
  int          failed_tests;
  int          seed;

  slm_bridge_top #(.CLKS_PER_BIT(CPB)) UUT (
    .sys_clk, .reset_all_cmd_w, .uart_rx_i(uart_rx), .sout_i(sout),
    .uart_tx_o(uart_tx), .slm_reset_n_o(slm_reset_n), .spi_o(spi)
  );

  uart_byte_driver #(.CLKS_PER_BIT(CPB)) pc_tx (
    .sys_clk, .send_i(send_req), .byte_i(pc_byte), .busy_o(drv_busy), .line_o(uart_rx)
  );

  uart_byte_monitor #(.CLKS_PER_BIT(CPB)) pc_rx (
    .sys_clk, .line_i(uart_tx), .count_o(rb_count), .byte_o(rb_byte),
    .stop_err_o(rb_stop_err)
  );

  spi_slave_model modulator (
    .sen_i(spi.sen), .sck_i(spi.sck), .sdat_i(spi.sdat), .miso_o(sout),
    .frame_o(last_frame), .bits_o(frame_bits), .count_o(frame_count)
  );

  always #(CLK_NS / 2) sys_clk = ~sys_clk;

  // cycles since reset fell
  always @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      since_rst <= 0;
    end else begin
      since_rst <= since_rst + 1;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  a_reset_outputs : assert property (
    @(posedge sys_clk) (reset_all_cmd_w && reset_settled) |->
      (spi.sen && !spi.sck && uart_tx && !slm_reset_n)
  ) else begin
    err_count++;
    $display("ERR @%0t ns: idle outputs wrong during reset", $time);
  end

  a_after_reset : assert property (
    @(posedge sys_clk) $fell(reset_all_cmd_w) |-> (spi.sen && !spi.sck && uart_tx)
  ) else begin
    err_count++;
    $display("ERR @%0t ns: idle outputs wrong right after reset", $time);
  end

  // low for exactly the stretch, high from then on
  a_slm_reset_release : assert property (
    @(posedge sys_clk) !reset_all_cmd_w |->
      (slm_reset_n == (since_rst >= `SLM_RESET_STRETCH))
  ) else begin
    err_count++;
    $display("ERR @%0t ns: slm_reset_n_o is %b, %0d cycles after reset",
             $time, slm_reset_n, since_rst);
  end

  a_frame_value : assert property (
    @(posedge sys_clk) (frame_count != $past(frame_count)) |->
      (last_frame == exp_frame_mem[frame_count[5:0] - 6'd1])
  ) else begin
    err_count++;
    $display("ERR @%0t ns: spi frame %h, expected %h", $time, last_frame,
             exp_frame_mem[frame_count[5:0] - 6'd1]);
  end

  a_frame_length : assert property (
    @(posedge sys_clk) (frame_count != $past(frame_count)) |-> (frame_bits == 16)
  ) else begin
    err_count++;
    $display("ERR @%0t ns: spi frame had %0d clocks", $time, frame_bits);
  end

  // a lone byte must not start a transfer
  a_odd_byte_held : assert property (
    @(posedge sys_clk) expect_idle |-> spi.sen
  ) else begin
    err_count++;
    $display("ERR @%0t ns: sen fell with only one byte received", $time);
  end

  a_readback_value : assert property (
    @(posedge sys_clk) (rb_count != $past(rb_count)) |->
      (rb_byte == ~exp_frame_mem[rb_count[5:0] - 6'd1][15:8])
  ) else begin
    err_count++;
    $display("ERR @%0t ns: readback %h, expected %h", $time, rb_byte,
             ~exp_frame_mem[rb_count[5:0] - 6'd1][15:8]);
  end

  a_readback_order : assert property (
    @(posedge sys_clk) rb_count <= frame_count
  ) else begin
    err_count++;
    $display("ERR @%0t ns: readback %0d before its frame", $time, rb_count);
  end

  a_readback_framing : assert property (
    @(posedge sys_clk) !$rose(rb_stop_err)
  ) else begin
    err_count++;
    $display("ERR @%0t ns: readback byte with a low stop bit", $time);
  end

  // one frame and one readback per expected pair
  a_test_counts : assert property (
    @(posedge sys_clk) test_end |-> (frame_count == exp_n && rb_count == exp_n)
  ) else begin
    err_count++;
    $display("ERR @%0t ns: %0d frames, %0d readbacks, expected %0d", $time,
             frame_count, rb_count, exp_n);
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////
  task automatic send_byte(input byte_t b);
    @(posedge sys_clk);
    #1;
    pc_byte  = b;
    send_req = 1'b1;
    wait (drv_busy);
    send_req = 1'b0;
    wait (!drv_busy);
  endtask

  task automatic expect_frame(input byte_t a, input byte_t b);
    exp_frame_mem[exp_n[5:0]] = {a, b};
    exp_n++;
  endtask

  task automatic send_pair(input byte_t a, input byte_t b);
    expect_frame(a, b);
    send_byte(a);
    send_byte(b);
  endtask

  task automatic wait_readbacks(input int n);
    int waited;
    waited = 0;
    while (rb_count < n && waited < RB_LIMIT) begin
      @(posedge sys_clk);
      waited++;
    end
    if (rb_count < n) begin
      err_count++;
      $display("readback %0d did not arrive within %0d cycles", n, RB_LIMIT);
    end
  endtask

  // pulse the count check, then report the test
  task automatic end_test(input string name);
    int errs;
    @(posedge sys_clk);
    #1;
    test_end = 1'b1;
    @(posedge sys_clk);
    #1;
    test_end = 1'b0;
    @(posedge sys_clk);
    errs = err_count - test_err_base;
    test_err_base = err_count;
    test_num++;
    if (errs != 0) begin
      failed_tests++;
    end
    $display("test %0d %s: %s, %0d errors", test_num, name, (errs == 0) ? "ok" : "FAILED",
             errs);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin
    int    rnd;
    int    i;
    byte_t a;
    byte_t b;
    sys_clk         = 1'b0;
    reset_all_cmd_w = 1'b1;
    send_req        = 1'b0;
    pc_byte         = '0;
    exp_n           = 0;
    reset_settled   = 1'b0;
    expect_idle     = 1'b0;
    test_end        = 1'b0;
    err_count       = 0;
    test_err_base   = 0;
    test_num        = 0;
    failed_tests    = 0;
    seed            = 32'h749698e6;
    // 8 cycles of reset
    @(posedge sys_clk);
    #1;
    reset_settled = 1'b1;
    repeat (7) @(posedge sys_clk);
    #1;
    reset_all_cmd_w = 1'b0;
    repeat (`SLM_RESET_STRETCH + 4) @(posedge sys_clk);
    end_test("reset state");

    send_pair(8'hA5, 8'h3C);
    wait_readbacks(exp_n);
    end_test("pairing");

    // first byte alone, then a quiet spell
    expect_frame(8'h5A, 8'hC3);
    expect_idle = 1'b1;
    send_byte(8'h5A);
    repeat (4 * CPB) @(posedge sys_clk);
    expect_idle = 1'b0;
    send_byte(8'hC3);
    wait_readbacks(exp_n);
    end_test("odd byte held");

    // two pairs back to back, then watch for extra bytes
    send_pair(8'h12, 8'h34);
    send_pair(8'hF0, 8'h0F);
    wait_readbacks(exp_n);
    repeat (20 * CPB) @(posedge sys_clk);
    end_test("readback");

    for (i = 0; i < STREAM_PAIRS; i++) begin
      rnd = $random(seed);
      a   = rnd[7:0];
      b   = rnd[15:8];
      send_pair(a, b);
      wait_readbacks(exp_n);
    end
    end_test("ordered stream");

    $display("tests run %0d, failed %0d, errors %0d", test_num, failed_tests, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // bound on the whole run
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
logic/slm_bridge_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/spi_cmd_pairer.sv
logic/spi_master.sv
logic/readback_queue.sv
logic/slm_reset_gen.sv
logic/slm_bridge_top.sv
tests/tb_slm_models.sv
tests/tb_slm_bridge.sv

//--- Makefile
# Verilator simulation of the bridge testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_slm_bridge
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
